// ==== src/cpuhandler_settings.svh ====
// Frame and word sizes are fixed for the serializer and CPU and must not change independently
`ifndef CPUHANDLER_SETTINGS_SVH
`define CPUHANDLER_SETTINGS_SVH

// Clock phases in one bus frame
// Phase 0 is the CPU step and the counter wraps after the last phase
`define CH_FRAME_PHASES 10

// Bytes in one bus word
// Address and write data go out in phases 1 to CH_WORD_BYTES
// The write flag follows in phase CH_WORD_BYTES + 1
// Read data is sampled in the CH_WORD_BYTES phases after that
// The frame length must equal 2 * CH_WORD_BYTES + 2
`define CH_WORD_BYTES 4

// Program counter increment per instruction
`define CH_INSTR_BYTES `CH_WORD_BYTES

`endif

// ==== src/cpuhandler_pkg.sv ====
// Types shared by the CPU and the byte serializer; the instruction format is fixed at 4+28 bits
package cpuhandler_pkg;

  // One bus word, used for addresses, data and the accumulator
  typedef logic [31:0] word_t;

  // Instruction opcode taken from bits 31..28 of a fetched word
  // Values 5 to 15 are not listed and decode as NOP
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,  // No operation
    OP_LDI   = 4'd1,  // Load immediate
    OP_ADDI  = 4'd2,  // Add immediate, wraps modulo 2^32
    OP_STORE = 4'd3,  // Write accumulator in the next frame
    OP_JMP   = 4'd4   // Jump to immediate
  } opcode_t;

  // Frame phase number, 0 to 9
  typedef logic [3:0] phase_t;

  // Opcode field position in an instruction word
  localparam int OPCODE_LSB = 28;

  // Zero-extended immediate from bits 27..0
  function automatic word_t imm_of(input word_t instr);
    word_t imm;
    imm = {4'b0000, instr[OPCODE_LSB-1:0]};
    return imm;
  endfunction

  // Opcode field of a fetched instruction
  function automatic opcode_t opcode_of(input word_t instr);
    opcode_t op;
    op = opcode_t'(instr[31:OPCODE_LSB]);
    return op;
  endfunction

endpackage

// ==== src/cpu_bus_if.sv ====
// CPU bus request and read data; the request must stay steady for a whole frame between steps
`timescale 1ns/1ps

interface cpu_bus_if;

  cpuhandler_pkg::word_t addr;   // Fetch or store address
  cpuhandler_pkg::word_t wdata;  // Store data, tracks the accumulator
  logic                  we;     // Set for a write frame
  cpuhandler_pkg::word_t rdata;  // Word assembled from the pins
  logic                  step;   // One-cycle pulse at phase 0

  // CPU side issues the request and consumes the returned word
  modport cpu (
    output addr,
    output wdata,
    output we,
    input  rdata,
    input  step
  );

  // Serializer side moves the request onto the pins
  modport serializer (
    input  addr,
    input  wdata,
    input  we,
    output rdata,
    output step
  );

endinterface

// ==== src/acc_cpu.sv ====
// Accumulator CPU stepping once per frame; no wait states, rdata must be valid at every step
`timescale 1ns/1ps
`include "cpuhandler_settings.svh"

module acc_cpu (
  input  logic      clk,
  input  logic      rst_n,
  cpu_bus_if.cpu    bus
);

  cpuhandler_pkg::word_t   pc;        // Program counter
  cpuhandler_pkg::word_t   acc;       // Accumulator
  cpuhandler_pkg::word_t   addr_q;    // Registered request address
  cpuhandler_pkg::word_t   wdata_q;   // Registered store data
  logic                    store_q;   // Pending store, current frame is a write

  cpuhandler_pkg::word_t   pc_next;
  cpuhandler_pkg::word_t   acc_next;
  cpuhandler_pkg::word_t   addr_next;
  logic                    store_next;

  cpuhandler_pkg::opcode_t op;
  cpuhandler_pkg::word_t   imm;
  cpuhandler_pkg::word_t   pc_inc;

  assign op     = cpuhandler_pkg::opcode_of(bus.rdata);
  assign imm    = cpuhandler_pkg::imm_of(bus.rdata);
  assign pc_inc = pc + cpuhandler_pkg::word_t'(`CH_INSTR_BYTES);

  // Next state for one step
  // A write frame carries no instruction, so rdata is ignored after it
  always_comb begin
    pc_next    = pc;
    acc_next   = acc;
    addr_next  = pc;      // Default request is a fetch at pc
    store_next = 1'b0;

    if (!store_q) begin
      pc_next   = pc_inc;
      addr_next = pc_inc;
      case (op)
        cpuhandler_pkg::OP_LDI: begin
          acc_next = imm;
        end
        cpuhandler_pkg::OP_ADDI: begin
          acc_next = acc + imm;  // Wraps modulo 2^32
        end
        cpuhandler_pkg::OP_STORE: begin
          addr_next  = imm;      // Write frame at the immediate address
          store_next = 1'b1;
        end
        cpuhandler_pkg::OP_JMP: begin
          pc_next   = imm;
          addr_next = imm;
        end
        default: begin
          // NOP and unused opcodes only advance pc
        end
      endcase
    end
  end

  // Architectural state, updated only on the phase-0 step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= '0;
      acc     <= '0;
      addr_q  <= '0;   // First request is a fetch at 0
      wdata_q <= '0;
      store_q <= 1'b0;
    end else if (bus.step) begin
      pc      <= pc_next;
      acc     <= acc_next;
      addr_q  <= addr_next;
      wdata_q <= acc_next;  // Equals acc on a store, since STORE keeps acc
      store_q <= store_next;
    end
  end

  // Request held for the whole frame
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.we    = store_q;

endmodule

// ==== src/bus_byte_serializer.sv ====
// Byte-wide frame serializer; the external side must answer within phases 6 to 9 of each frame
`timescale 1ns/1ps
`include "cpuhandler_settings.svh"

module bus_byte_serializer (
  input  logic             clk,
  input  logic             rst_n,
  cpu_bus_if.serializer    bus,
  input  logic [7:0]       uio_in,
  output logic [7:0]       uo_out,
  output logic [7:0]       uio_out,
  output logic [7:0]       uio_oe
);

  localparam int IDX_W = $clog2(`CH_WORD_BYTES);

  // Phase map derived from the word size
  localparam cpuhandler_pkg::phase_t FIRST_PHASE =
    cpuhandler_pkg::phase_t'(1);
  localparam cpuhandler_pkg::phase_t LAST_PHASE =
    cpuhandler_pkg::phase_t'(`CH_FRAME_PHASES - 1);
  localparam cpuhandler_pkg::phase_t ADDR_LAST =
    cpuhandler_pkg::phase_t'(`CH_WORD_BYTES);
  localparam cpuhandler_pkg::phase_t FLAG_PHASE =
    cpuhandler_pkg::phase_t'(`CH_WORD_BYTES + 1);
  localparam cpuhandler_pkg::phase_t RD_FIRST =
    cpuhandler_pkg::phase_t'(`CH_WORD_BYTES + 2);

  cpuhandler_pkg::phase_t phase;       // Current frame phase
  logic                   addr_phase;  // Address and write-data bytes go out
  logic                   rd_phase;    // A read byte is sampled
  logic [IDX_W-1:0]       wr_idx;      // Outgoing byte index, LSB first
  logic [IDX_W-1:0]       rd_idx;      // Incoming byte index, LSB first

  assign addr_phase = (phase >= FIRST_PHASE) && (phase <= ADDR_LAST);
  assign rd_phase   = (phase >= RD_FIRST) && (phase <= LAST_PHASE);
  assign wr_idx     = IDX_W'(phase - FIRST_PHASE);
  assign rd_idx     = IDX_W'(phase - RD_FIRST);

  // CPU updates while the counter holds phase 0
  assign bus.step = (phase == '0);

  // Pins are driven only during a write frame
  assign uio_oe = {8{bus.we}};

  // Phase counter
  // Reset starts at phase 1, so the first frame has no phase 0 step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= FIRST_PHASE;
    end else if (phase == LAST_PHASE) begin
      phase <= '0;
    end else begin
      phase <= phase + cpuhandler_pkg::phase_t'(1);
    end
  end

  // Output byte registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uo_out  <= '0;
      uio_out <= '0;
    end else if (addr_phase) begin
      uo_out  <= bus.addr[8*wr_idx +: 8];
      uio_out <= bus.wdata[8*wr_idx +: 8];
    end else if (phase == FLAG_PHASE) begin
      uo_out  <= {7'b0000000, bus.we};  // Write flag in bit 0, uio_out holds
    end
  end

  // Read word assembly
  // Bytes land LSB first and the full word is stable at the next step
  always_ff @(posedge clk) begin
    if (rd_phase) begin
      bus.rdata[8*rd_idx +: 8] <= uio_in;
    end
  end

endmodule

// ==== src/cpuhandler_top.sv ====
// CPU with a 32-bit bus carried over 8-bit pins in a ten-phase frame; uio_in must be valid phases 6-9
`timescale 1ns/1ps

module cpuhandler_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] uio_in,    // Read data bytes from the external memory
  output logic [7:0] uo_out,    // Address bytes, then the write flag
  output logic [7:0] uio_out,   // Write data bytes
  output logic [7:0] uio_oe     // All ones on a write frame
);

  // Request and read data between CPU and serializer
  cpu_bus_if bus ();

  // Accumulator CPU
  acc_cpu u_cpu (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.cpu)
  );

  // Frame sequencer and pin drivers
  bus_byte_serializer u_serializer (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus.serializer),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

endmodule

// ==== tests/cpuhandler_tb.sv ====
// Testbench acting as external memory; the 1 KB memory aliases on higher address bits
`timescale 1ns/1ps
`include "cpuhandler_settings.svh"

module cpuhandler_tb;

  localparam int CLK_PERIOD     = 10;
  localparam int MEM_WORDS      = 256;             // Byte address bits 9..2 pick a word
  localparam int PROG_A_FRAMES  = 24;
  localparam int PROG_B_FRAMES  = 17;              // Four full loop passes
  localparam int RAND_FRAMES    = 300;
  localparam int RESTART_FRAMES = 6;
  localparam int TOTAL_FRAMES   =
    PROG_A_FRAMES + PROG_B_FRAMES + RAND_FRAMES + RESTART_FRAMES;
  localparam int WATCHDOG_NS    = (TOTAL_FRAMES * `CH_FRAME_PHASES + 100) * CLK_PERIOD;

  localparam cpuhandler_pkg::phase_t LAST_PHASE = `CH_FRAME_PHASES - 1;
  localparam cpuhandler_pkg::phase_t FLAG_PHASE = `CH_WORD_BYTES + 1;
  localparam cpuhandler_pkg::phase_t RD_FIRST   = `CH_WORD_BYTES + 2;

  localparam logic [27:0] ADDR_MASK = 28'h000_03FC;  // Aligned and inside the memory

  // Expected CPU state and bus request after a step
  typedef struct packed {
    cpuhandler_pkg::word_t pc;
    cpuhandler_pkg::word_t acc;
    cpuhandler_pkg::word_t addr;
    cpuhandler_pkg::word_t wdata;
    logic                  store;
  } cpu_state_t;

  logic       clk;
  logic       rst_n;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  cpuhandler_pkg::word_t  mem [MEM_WORDS];
  cpu_state_t             m;            // Reference model state
  cpuhandler_pkg::phase_t cur_phase;    // Phase the counter holds until the next rising edge
  logic                   tracking;     // Model follows the DUT while reset is released
  int                     frames_done;  // Steps seen since the start
  cpuhandler_pkg::word_t  drv_word;     // Word driven on uio_in in this frame
  cpuhandler_pkg::word_t  addr_seen;    // Address assembled from uo_out
  cpuhandler_pkg::word_t  wdata_seen;   // Write data assembled from uio_out

  cpuhandler_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Print the reason and the fail message and stop the run
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at time %0t: %s is %02h, expected %02h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_word(input string what, input cpuhandler_pkg::word_t got,
                            input cpuhandler_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at time %0t: %s is %08h, expected %08h",
                          $time, what, got, exp));
    end
  endtask

  function automatic int mem_index(input cpuhandler_pkg::word_t addr);
    return int'(addr[9:2]);
  endfunction

  function automatic logic [7:0] mem_byte(input cpuhandler_pkg::word_t addr, input int idx);
    cpuhandler_pkg::word_t w;
    w = mem[mem_index(addr)];
    return w[8*idx +: 8];
  endfunction

  function automatic cpuhandler_pkg::word_t enc(input cpuhandler_pkg::opcode_t op,
                                                input logic [27:0] imm);
    return {op, imm};
  endfunction

  // One CPU step from the instruction rules
  function automatic cpu_state_t ref_step(input cpuhandler_pkg::word_t pc,
                                          input cpuhandler_pkg::word_t acc,
                                          input logic store,
                                          input cpuhandler_pkg::word_t fetched);
    cpu_state_t            n;
    logic [3:0]            op;
    cpuhandler_pkg::word_t imm;
    op      = fetched[31:28];
    imm     = {4'h0, fetched[27:0]};
    n.pc    = pc;
    n.acc   = acc;
    n.addr  = pc;          // After a write frame, fetch at pc
    n.store = 1'b0;
    if (!store) begin
      n.pc   = pc + 32'd4;
      n.addr = pc + 32'd4;
      case (op)
        cpuhandler_pkg::OP_LDI: n.acc = imm;
        cpuhandler_pkg::OP_ADDI: n.acc = acc + imm;
        cpuhandler_pkg::OP_STORE: begin
          n.addr  = imm;
          n.store = 1'b1;
        end
        cpuhandler_pkg::OP_JMP: begin
          n.pc   = imm;
          n.addr = imm;
        end
        default: begin
          // NOP and opcodes 5 to 15
        end
      endcase
    end
    n.wdata = n.acc;       // Write data follows the accumulator
    return n;
  endfunction

  // Checks for the edge at which the counter held phase ph
  task automatic check_edge(input cpuhandler_pkg::phase_t ph);
    int k;
    if (ph == 0) begin
      check_byte("uo_out hold at the step", uo_out, {7'b0000000, m.store});
      check_byte("uio_out hold at the step", uio_out, m.wdata[31:24]);
      m = ref_step(m.pc, m.acc, m.store, drv_word);
      frames_done++;
    end else if (ph <= `CH_WORD_BYTES) begin
      k = int'(ph) - 1;
      check_byte("write data byte on uio_out", uio_out, m.wdata[8*k +: 8]);
      addr_seen[8*k +: 8]  = uo_out;
      wdata_seen[8*k +: 8] = uio_out;
      if (k == `CH_WORD_BYTES - 1) begin
        check_word("frame address", addr_seen, m.addr);
      end
    end else if (ph == FLAG_PHASE) begin
      check_flag("write flag", uo_out[0], m.store);
      check_byte("upper bits of the flag byte", {1'b0, uo_out[7:1]}, 8'h00);
      check_byte("uio_out hold in flag phase", uio_out, m.wdata[31:24]);
      if (m.store) begin
        mem[mem_index(addr_seen)] = wdata_seen;  // Memory takes the write
      end
    end else begin
      check_byte("uo_out hold in read phase", uo_out, {7'b0000000, m.store});
      check_byte("uio_out hold in read phase", uio_out, m.wdata[31:24]);
    end
    check_byte("uio_oe", uio_oe, {8{m.store}});
  endtask

  // Compare process runs shortly after the rising edge when outputs are stable
  always @(posedge clk) begin : compare_pins
    cpuhandler_pkg::phase_t edge_phase;
    #1;
    if (tracking) begin
      edge_phase = cur_phase;
      if (cur_phase == LAST_PHASE) begin
        cur_phase = '0;
      end else begin
        cur_phase = cur_phase + 4'd1;
      end
      check_edge(edge_phase);
    end
  end

  // Memory answers with the word at the frame address in LSB first order
  always @(negedge clk) begin : drive_read_bytes
    logic [7:0] b;
    int         idx;
    if (tracking && cur_phase >= RD_FIRST) begin
      idx = int'(cur_phase) - int'(RD_FIRST);
      b   = mem_byte(m.addr, idx);
      drv_word[8*idx +: 8] = b;
      uio_in <= b;
    end else begin
      uio_in <= 8'h00;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("Timeout: the frames did not complete within the expected time");
  end

  task automatic hold_reset();
    @(negedge clk);
    rst_n    = 1'b0;
    tracking = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Reset values checked before the model restarts
  task automatic release_reset();
    @(negedge clk);
    check_byte("uo_out after reset", uo_out, 8'h00);
    check_byte("uio_out after reset", uio_out, 8'h00);
    check_byte("uio_oe after reset", uio_oe, 8'h00);
    m         = '0;            // Fetch at 0 with write flag 0
    cur_phase = 4'd1;          // First frame has no phase 0
    rst_n     = 1'b1;
    tracking  = 1'b1;
  endtask

  task automatic run_frames(input int n);
    int target;
    target = frames_done + n;
    wait (frames_done >= target);
    @(negedge clk);
  endtask

  // NOP words carrying the byte address in the immediate
  task automatic fill_nop();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {4'h0, 18'h2A5A5, 10'(i << 2)};
    end
  endtask

  // LDI, sixteen ADDI with a wrap, STORE, then a jump to itself
  task automatic load_sum_program();
    fill_nop();
    mem[0] = enc(cpuhandler_pkg::OP_LDI, 28'hFFF_FFFF);
    for (int i = 1; i <= 16; i++) begin
      mem[i] = enc(cpuhandler_pkg::OP_ADDI, 28'hFFF_FFFF);
    end
    mem[17] = enc(cpuhandler_pkg::OP_STORE, 28'h000_0300);
    mem[18] = enc(cpuhandler_pkg::OP_JMP, 28'h000_0048);  // Address of this word
  endtask

  // Loop body ADDI, STORE, JMP back
  task automatic load_loop_program();
    fill_nop();
    mem[0] = enc(cpuhandler_pkg::OP_LDI, 28'h000_0005);
    mem[1] = enc(cpuhandler_pkg::OP_ADDI, 28'h000_0003);
    mem[2] = enc(cpuhandler_pkg::OP_STORE, 28'h000_0100);
    mem[3] = enc(cpuhandler_pkg::OP_JMP, 28'h000_0004);
  endtask

  task automatic fill_random();
    logic [3:0]  op;
    logic [27:0] imm;
    for (int i = 0; i < MEM_WORDS; i++) begin
      op  = 4'($urandom_range(15, 0));
      imm = 28'($urandom);
      if (op == cpuhandler_pkg::OP_STORE || op == cpuhandler_pkg::OP_JMP) begin
        imm = imm & ADDR_MASK;
      end
      mem[i] = {op, imm};
    end
  endtask

  initial begin
    void'($urandom(24));
    rst_n       = 1'b0;
    uio_in      = 8'h00;
    tracking    = 1'b0;
    cur_phase   = 4'd1;
    frames_done = 0;
    m           = '0;
    drv_word    = '0;
    addr_seen   = '0;
    wdata_seen  = '0;

    // Accumulator sum with wrap stored at 0x300
    hold_reset();
    load_sum_program();
    release_reset();
    run_frames(PROG_A_FRAMES);
    check_word("sum stored at 0x300", mem[mem_index(32'h0000_0300)], 32'h0FFF_FFEF);

    // Jump loop where acc grows by 3 per pass
    hold_reset();
    load_loop_program();
    release_reset();
    run_frames(PROG_B_FRAMES);
    check_word("loop value at 0x100", mem[mem_index(32'h0000_0100)], 32'h0000_0011);

    hold_reset();
    fill_random();
    release_reset();
    run_frames(RAND_FRAMES);

    // Reset again in the middle of a frame
    repeat (4) @(negedge clk);
    hold_reset();
    load_sum_program();
    release_reset();
    run_frames(RESTART_FRAMES);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+src
src/cpuhandler_pkg.sv
src/cpu_bus_if.sv
src/acc_cpu.sv
src/bus_byte_serializer.sv
src/cpuhandler_top.sv
tests/cpuhandler_tb.sv

// ==== Bender.yml ====
package:
  name: cpuhandler

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cpuhandler_pkg.sv
      - src/cpu_bus_if.sv
      - src/acc_cpu.sv
      - src/bus_byte_serializer.sv
      - src/cpuhandler_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - tests/cpuhandler_tb.sv
